//--- sim.f
verilog/ni_pkg.sv
verilog/input_block.sv
verilog/feistel_engine.sv
verilog/output_control_unit.sv
verilog/output_block.sv
verilog/network_interface.sv
testbench/tb_network_interface.sv

//--- Makefile
VERILATOR  = verilator
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_network_interface
FILE_LIST  = sim.f
OBJ_DIR    = obj_dir
PASS_MSG   = Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/tb_network_interface.sv
`timescale 1ns/10ps

module tb_network_interface;
	import ni_pkg::*;

	localparam logic [31:0] SEED = 32'ha13a;
	localparam int NUM_TESTS = 4;
	localparam int CYCLES_PER_TEST = 2000;
	// upstream router owns one full request of buffer space
	localparam int UP_CREDITS = PACKET_FLITS;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic [CHANNEL_WIDTH-1:0] in_flit = '0;
	logic in_valid = 1'b0;
	logic credit_return;
	logic [CHANNEL_WIDTH-1:0] out_flit;
	logic out_valid;
	logic credit_grant = 1'b0;

	// expected reply flits, pushed by the sender and indexed by received count
	logic [31:0] exp_q[$];
	logic [31:0] exp_head = '0;
	int flits_expected = 0;
	int flits_received = 0;
	// counts as they stood before the flit of the current cycle
	int recv_before = 0;
	int down_before = OUT_CREDITS;
	// router models
	int flits_sent = 0;
	int credits_returned = 0;
	int up_credits;
	int down_credits = OUT_CREDITS;
	int grant_delay = 0;
	logic withhold = 1'b0;
	logic seen_done = 1'b0;
	// separate generators for packet data and grant delays
	logic [31:0] data_lfsr = SEED;
	logic [31:0] grant_lfsr = SEED;
	int error_count = 0;
	int tests_failed = 0;

	network_interface i_dut
	(
		.clk           (clk),
		.reset         (reset),
		.in_flit       (in_flit),
		.in_valid      (in_valid),
		.credit_return (credit_return),
		.out_flit      (out_flit),
		.out_valid     (out_valid),
		.credit_grant  (credit_grant)
	);

	always #10 clk = ~clk;

	assign up_credits = UP_CREDITS - flits_sent + credits_returned;

	// galois lfsr, taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one step per bit, low bit of the state is the bit taken
	task automatic take_bits(inout logic [31:0] state, input int n, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++)
		begin
			bits = {bits[30:0], state[0]};
			state = lfsr_step(state);
		end
	endtask

	// reference feistel: new L = R, new R = L ^ (rotl5(R) + K + i)
	function automatic logic [63:0] cipher_model(input logic [31:0] a, b, k0, k1);
		logic [31:0] l;
		logic [31:0] r;
		logic [31:0] k;
		logic [31:0] f;
		l = a;
		r = b;
		for (int i = 0; i < 8; i++)
		begin
			k = (i % 2 == 0) ? k0 : k1;
			f = l ^ ({r[26:0], r[31:27]} + k + 32'(i));
			l = r;
			r = f;
		end
		return {l, r};
	endfunction

	// downstream router and scoreboard bookkeeping, mid cycle while outputs are stable
	always @(negedge clk)
	begin
		logic [31:0] gap;
		// downstream router frees slots after a random 0..3 cycle gap
		credit_grant = 1'b0;
		if (!reset && !withhold && down_credits < OUT_CREDITS)
		begin
			if (grant_delay == 0)
			begin
				credit_grant = 1'b1;
				take_bits(grant_lfsr, 2, gap);
				grant_delay = int'(gap);
			end
			else
				grant_delay = grant_delay - 1;
		end
		// expected flit for this cycle
		exp_head = (flits_received < exp_q.size()) ? exp_q[flits_received] : '0;
		recv_before = flits_received;
		down_before = down_credits;
		if (reset)
		begin
			down_credits = OUT_CREDITS;
			seen_done = 1'b0;
		end
		else
		begin
			down_credits = down_credits + int'(credit_grant) - int'(out_valid);
			if (i_dut.done_strobe)
				seen_done = 1'b1;
			if (credit_return)
				credits_returned = credits_returned + 1;
			if (out_valid)
				flits_received = flits_received + 1;
		end
	end

	a_reply_value: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> out_flit == exp_head)
	else
	begin
		$display("[FAIL] %0t out_flit: got %h expected %h", $time,
			$sampled(out_flit), $sampled(exp_head));
		error_count++;
	end

	a_reply_expected: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> recv_before < flits_expected)
	else
	begin
		$display("%0t: reply flit arrived with no reply outstanding", $time);
		error_count++;
	end

	// channel idles at zero
	a_idle_zero: assert property (@(posedge clk) disable iff (reset)
		!out_valid |-> out_flit == '0)
	else
	begin
		$display("[FAIL] %0t out_flit: got %h expected %h", $time, $sampled(out_flit), 32'h0);
		error_count++;
	end

	a_quiet_after_reset: assert property (@(posedge clk) disable iff (reset)
		!seen_done |-> !out_valid && !credit_return)
	else
	begin
		$display("%0t: reply or credit activity before the first cipher result", $time);
		error_count++;
	end

	a_downstream_credit: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> down_before > 0)
	else
	begin
		$display("%0t: reply flit sent while downstream had no free slot", $time);
		error_count++;
	end

	a_upstream_credit: assert property (@(posedge clk) disable iff (reset)
		up_credits >= 0 && up_credits <= UP_CREDITS)
	else
	begin
		$display("%0t: upstream credit count out of range (%0d)", $time, $sampled(up_credits));
		error_count++;
	end

	// router side: wait for a credit, then one flit per falling edge
	task automatic send_flit(input logic [31:0] data);
		while (up_credits <= 0)
			@(negedge clk);
		in_flit = data;
		in_valid = 1'b1;
		flits_sent = flits_sent + 1;
		@(negedge clk);
		in_valid = 1'b0;
		in_flit = '0;
	endtask

	task automatic send_packet(input logic [31:0] header, a, b, k0, k1);
		logic [63:0] result;
		result = cipher_model(a, b, k0, k1);
		// reply: swapped header, low half, high half, trace words
		exp_q.push_back({header[15:0], header[31:16]});
		exp_q.push_back(result[31:0]);
		exp_q.push_back(result[63:32]);
		exp_q.push_back(32'h4e55_4c31);
		exp_q.push_back(32'h4e55_4c32);
		flits_expected = flits_expected + PACKET_FLITS;
		send_flit(header);
		send_flit(a);
		send_flit(b);
		send_flit(k0);
		send_flit(k1);
	endtask

	task automatic send_random_packet();
		logic [31:0] w [5];
		for (int j = 0; j < 5; j++)
			take_bits(data_lfsr, 32, w[j]);
		send_packet(w[0], w[1], w[2], w[3], w[4]);
	endtask

	// all replies in and all upstream credits back
	task automatic wait_drained(input int limit);
		int cycles;
		cycles = 0;
		while ((flits_received != flits_expected || up_credits != UP_CREDITS) && cycles < limit)
		begin
			@(negedge clk);
			cycles++;
		end
		if (cycles >= limit)
		begin
			$display("%0t: replies or upstream credits still outstanding", $time);
			error_count++;
		end
	endtask

	task automatic finish_test(input string name, input int err_start, input int ret_start,
		input int packets);
		assert (credits_returned - ret_start == packets * PACKET_FLITS)
		else
		begin
			$display("[FAIL] %0t credit_return pulses: got %0d expected %0d", $time,
				credits_returned - ret_start, packets * PACKET_FLITS);
			error_count++;
		end
		if (error_count == err_start)
			$display("test %s: ok", name);
		else
		begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, error_count - err_start);
		end
	endtask

	initial
	begin
		int err_start;
		int ret_start;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// idle channel after reset
		err_start = error_count;
		ret_start = credits_returned;
		repeat (10) @(negedge clk);
		finish_test("reset_idle", err_start, ret_start, 0);

		err_start = error_count;
		ret_start = credits_returned;
		send_packet(32'h0012_0034, 32'h0123_4567, 32'h89ab_cdef, 32'h0f1e_2d3c, 32'h4b5a_6978);
		wait_drained(500);
		finish_test("single_packet", err_start, ret_start, 1);

		err_start = error_count;
		ret_start = credits_returned;
		for (int p = 0; p < 10; p++)
			send_random_packet();
		wait_drained(1000);
		finish_test("burst_of_ten", err_start, ret_start, 10);

		// no grants: first reply stalls after four flits, second packet queues
		err_start = error_count;
		ret_start = credits_returned;
		withhold = 1'b1;
		send_random_packet();
		send_random_packet();
		repeat (40) @(negedge clk);
		assert (flits_received < flits_expected)
		else
		begin
			$display("%0t: reply did not stall while grants were withheld", $time);
			error_count++;
		end
		withhold = 1'b0;
		wait_drained(1000);
		finish_test("withheld_grants", err_start, ret_start, 2);

		$display("tests run: %0d, tests failed: %0d, errors: %0d", NUM_TESTS, tests_failed,
			error_count);
		if (error_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	// watchdog
	initial
	begin
		repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
		$display("watchdog expired: the tests did not complete in time");
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- verilog/network_interface.sv
`timescale 1ns/10ps

module network_interface
(
	input  logic clk,
	input  logic reset,
	input  logic [ni_pkg::CHANNEL_WIDTH-1:0] in_flit,
	input  logic in_valid,
	output logic credit_return,
	output logic [ni_pkg::CHANNEL_WIDTH-1:0] out_flit,
	output logic out_valid,
	input  logic credit_grant
);
	import ni_pkg::*;

	logic cipher_start;
	logic done_strobe;
	logic zero_credits;
	logic [2*CHANNEL_WIDTH-1:0] plaintext;
	logic [2*CHANNEL_WIDTH-1:0] key;
	logic [2*CHANNEL_WIDTH-1:0] ciphertext;
	logic [CHANNEL_WIDTH-1:0] shifted_header;

	// request side
	input_block i_input_block
	(
		.clk            (clk),
		.reset          (reset),
		.in_flit        (in_flit),
		.in_valid       (in_valid),
		.credit_return  (credit_return),
		.zero_credits   (zero_credits),
		.cipher_start   (cipher_start),
		.plaintext      (plaintext),
		.key            (key),
		.shifted_header (shifted_header),
		.done_strobe    (done_strobe)
	);

	// processing element
	feistel_engine i_feistel_engine
	(
		.clk          (clk),
		.reset        (reset),
		.cipher_start (cipher_start),
		.plaintext    (plaintext),
		.key          (key),
		.done_strobe  (done_strobe),
		.ciphertext   (ciphertext)
	);

	// reply side
	output_block i_output_block
	(
		.clk            (clk),
		.reset          (reset),
		.done_strobe    (done_strobe),
		.ciphertext     (ciphertext),
		.shifted_header (shifted_header),
		.zero_credits   (zero_credits),
		.credit_grant   (credit_grant),
		.out_flit       (out_flit),
		.out_valid      (out_valid)
	);

endmodule

//--- verilog/output_block.sv
`timescale 1ns/10ps

module output_block
(
	input  logic clk,
	input  logic reset,
	input  logic done_strobe,
	input  logic [2*ni_pkg::CHANNEL_WIDTH-1:0] ciphertext,
	input  logic [ni_pkg::CHANNEL_WIDTH-1:0] shifted_header,
	output logic zero_credits,
	input  logic credit_grant,
	output logic [ni_pkg::CHANNEL_WIDTH-1:0] out_flit,
	output logic out_valid
);
	import ni_pkg::*;

	out_sel_t selector;
	logic [2*CHANNEL_WIDTH-1:0] result_q;
	logic [CHANNEL_WIDTH-1:0] flit_mux;

	// sequencing and downstream credits
	output_control_unit i_output_control_unit
	(
		.clk          (clk),
		.reset        (reset),
		.credit_grant (credit_grant),
		.done_strobe  (done_strobe),
		.zero_credits (zero_credits),
		.selector     (selector),
		.out_valid    (out_valid)
	);

	// result capture, key material is not kept
	always_ff @(posedge clk)
	begin
		if (done_strobe)
			result_q <= ciphertext;
	end

	// reply flit select
	always_comb
	begin
		case (selector)
			SEL_HEADER:  flit_mux = shifted_header;
			SEL_CIPH_LO: flit_mux = result_q[0 +: CHANNEL_WIDTH];
			SEL_CIPH_HI: flit_mux = result_q[CHANNEL_WIDTH +: CHANNEL_WIDTH];
			SEL_NUL1:    flit_mux = NUL1_FLIT;
			SEL_NUL2:    flit_mux = NUL2_FLIT;
			default:     flit_mux = '0;
		endcase
	end

	// channel stays zero on stalled and idle cycles
	assign out_flit = out_valid ? flit_mux : '0;

endmodule

//--- verilog/output_control_unit.sv
`timescale 1ns/10ps

module output_control_unit
(
	input  logic clk,
	input  logic reset,
	input  logic credit_grant,
	input  logic done_strobe,
	output logic zero_credits,
	output ni_pkg::out_sel_t selector,
	output logic out_valid
);
	import ni_pkg::*;

	logic [CREDIT_WIDTH-1:0] credits;

	// a flit leaves only with a downstream credit in hand
	assign out_valid = (selector != SEL_IDLE) && (credits != '0);

	// output path busy or starved, so the input block must hold its packet
	assign zero_credits = (credits == '0) || (selector != SEL_IDLE) || done_strobe;

	// downstream credit counter
	always_ff @(posedge clk)
	begin
		if (reset)
			credits <= CREDIT_WIDTH'(OUT_CREDITS);
		else
		begin
			case ({credit_grant, out_valid})
				2'b10: credits <= credits + 1'b1;
				2'b01: credits <= credits - 1'b1;
				// grant and send in the same cycle cancel
				default: credits <= credits;
			endcase
		end
	end

	// sequencer, header first then down to NUL2 and back to idle
	always_ff @(posedge clk)
	begin
		if (reset)
			selector <= SEL_IDLE;
		else if (done_strobe)
			selector <= SEL_HEADER;
		else if (out_valid)
			selector <= out_sel_t'(selector - 1'b1);
		// without a credit the position is held
	end

	// a new result may only arrive once the last reply has left
	a_done_idle: assert property (@(posedge clk) disable iff (reset)
		done_strobe |-> selector == SEL_IDLE);

	// downstream never grants a slot it was not sent
	a_credit_max: assert property (@(posedge clk) disable iff (reset)
		credit_grant && !out_valid |-> credits < CREDIT_WIDTH'(OUT_CREDITS));

endmodule

//--- verilog/feistel_engine.sv
`timescale 1ns/10ps

module feistel_engine
(
	input  logic clk,
	input  logic reset,
	input  logic cipher_start,
	input  logic [2*ni_pkg::CHANNEL_WIDTH-1:0] plaintext,
	input  logic [2*ni_pkg::CHANNEL_WIDTH-1:0] key,
	output logic done_strobe,
	output logic [2*ni_pkg::CHANNEL_WIDTH-1:0] ciphertext
);
	import ni_pkg::*;

	logic [CHANNEL_WIDTH-1:0] l_q;
	logic [CHANNEL_WIDTH-1:0] r_q;
	logic [CHANNEL_WIDTH-1:0] l_in;
	logic [CHANNEL_WIDTH-1:0] r_in;
	logic [CHANNEL_WIDTH-1:0] round_key;
	logic [CHANNEL_WIDTH-1:0] mix;
	logic [$clog2(CIPHER_ROUNDS)-1:0] round_q;
	logic [$clog2(CIPHER_ROUNDS)-1:0] round_idx;
	logic busy;

	// round 0 runs straight off the plaintext in the start cycle
	assign l_in = cipher_start ? plaintext[CHANNEL_WIDTH +: CHANNEL_WIDTH] : l_q;
	assign r_in = cipher_start ? plaintext[0 +: CHANNEL_WIDTH] : r_q;
	assign round_idx = cipher_start ? '0 : round_q;

	// even rounds take key word 0, odd rounds key word 1
	assign round_key = round_idx[0] ? key[0 +: CHANNEL_WIDTH] : key[CHANNEL_WIDTH +: CHANNEL_WIDTH];

	// rotl(R, 5) + K + i, modulo 2^32
	assign mix = ((r_in << ROUND_ROTATE) | (r_in >> (CHANNEL_WIDTH - ROUND_ROTATE)))
		+ round_key + CHANNEL_WIDTH'(round_idx);

	// round counter and done pulse
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			done_strobe <= 1'b0;
			round_q <= '0;
		end
		else
		begin
			done_strobe <= 1'b0;
			if (cipher_start)
			begin
				busy <= 1'b1;
				round_q <= 1'b1;
			end
			else if (busy)
			begin
				round_q <= round_q + 1'b1;
				// last round lands with the done pulse
				if (int'(round_q) == CIPHER_ROUNDS - 1)
				begin
					busy <= 1'b0;
					done_strobe <= 1'b1;
				end
			end
		end
	end

	// one feistel round per cycle
	always_ff @(posedge clk)
	begin
		if (cipher_start || busy)
		begin
			l_q <= r_in;
			r_q <= l_in ^ mix;
		end
	end

	assign ciphertext = {l_q, r_q};

	// the input block must wait for the previous run to finish
	a_start_idle: assert property (@(posedge clk) disable iff (reset)
		cipher_start |-> !busy);

endmodule

//--- verilog/input_block.sv
`timescale 1ns/10ps

module input_block
(
	input  logic clk,
	input  logic reset,
	input  logic [ni_pkg::CHANNEL_WIDTH-1:0] in_flit,
	input  logic in_valid,
	output logic credit_return,
	input  logic zero_credits,
	output logic cipher_start,
	output logic [2*ni_pkg::CHANNEL_WIDTH-1:0] plaintext,
	output logic [2*ni_pkg::CHANNEL_WIDTH-1:0] key,
	output logic [ni_pkg::CHANNEL_WIDTH-1:0] shifted_header,
	input  logic done_strobe
);
	import ni_pkg::*;

	in_state_t state;
	in_state_t state_next;
	logic [CREDIT_WIDTH-1:0] flit_cnt;
	logic [CREDIT_WIDTH-1:0] return_cnt;
	logic [CREDIT_WIDTH-1:0] used_slots;
	logic [CHANNEL_WIDTH-1:0] header_q;
	logic packet_ready;
	logic last_flit;

	// fifth flit of a request
	assign last_flit = in_valid && (flit_cnt == CREDIT_WIDTH'(PACKET_FLITS - 1));

	// flit counter, plus a flag for a complete packet not yet started
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			flit_cnt <= '0;
			packet_ready <= 1'b0;
		end
		else
		begin
			if (last_flit)
				flit_cnt <= '0;
			else if (in_valid)
				flit_cnt <= flit_cnt + 1'b1;
			if (last_flit)
				packet_ready <= 1'b1;
			else if (cipher_start)
				packet_ready <= 1'b0;
		end
	end

	// file each flit by position: header, A, B, key 0, key 1
	always_ff @(posedge clk)
	begin
		if (in_valid)
		begin
			case (flit_cnt)
				3'd0: header_q <= in_flit;
				3'd1: plaintext[CHANNEL_WIDTH +: CHANNEL_WIDTH] <= in_flit;
				3'd2: plaintext[0 +: CHANNEL_WIDTH] <= in_flit;
				3'd3: key[CHANNEL_WIDTH +: CHANNEL_WIDTH] <= in_flit;
				default: key[0 +: CHANNEL_WIDTH] <= in_flit;
			endcase
		end
	end

	// swap source and destination halves, held until the next start
	always_ff @(posedge clk)
	begin
		if (cipher_start)
			shifted_header <= {header_q[0 +: CHANNEL_WIDTH/2],
				header_q[CHANNEL_WIDTH/2 +: CHANNEL_WIDTH/2]};
	end

	// FSM: wait for the output path, run the cipher, free the buffer
	always_comb
	begin
		state_next = state;
		case (state)
			COLLECT:
				if (last_flit || packet_ready)
					state_next = WAIT_OUT;
			WAIT_OUT:
				if (!zero_credits)
					state_next = RUN;
			RUN:
				if (done_strobe)
					state_next = RETURN;
			default:
				if (return_cnt == CREDIT_WIDTH'(PACKET_FLITS - 1))
					state_next = (last_flit || packet_ready) ? WAIT_OUT : COLLECT;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= COLLECT;
			return_cnt <= '0;
		end
		else
		begin
			state <= state_next;
			// one returned credit per cycle in RETURN
			if (state == RETURN)
				return_cnt <= (state_next == RETURN) ? return_cnt + 1'b1 : '0;
		end
	end

	assign cipher_start = (state == WAIT_OUT) && !zero_credits;
	assign credit_return = (state == RETURN);

	// buffer slots held against the upstream router's credits
	always_ff @(posedge clk)
	begin
		if (reset)
			used_slots <= '0;
		else if (in_valid && !credit_return)
			used_slots <= used_slots + 1'b1;
		else if (!in_valid && credit_return)
			used_slots <= used_slots - 1'b1;
	end

	// a flit may only land on a free slot
	a_no_overrun: assert property (@(posedge clk) disable iff (reset)
		in_valid |-> (used_slots < CREDIT_WIDTH'(PACKET_FLITS)) || credit_return);

endmodule

//--- verilog/ni_pkg.sv
package ni_pkg;

	// flit width on both router channels
	localparam int CHANNEL_WIDTH = 32;
	// request and reply packets are both five flits long
	localparam int PACKET_FLITS = 5;

	// downstream credits after reset are fewer than one packet so replies stall
	localparam int OUT_CREDITS = 4;
	localparam int CREDIT_WIDTH = 3;

	// feistel round count and round function rotation
	localparam int CIPHER_ROUNDS = 8;
	localparam int ROUND_ROTATE = 5;

	// ascii trace words closing every reply
	localparam logic [CHANNEL_WIDTH-1:0] NUL1_FLIT = "NUL1";
	localparam logic [CHANNEL_WIDTH-1:0] NUL2_FLIT = "NUL2";

	// reply flit currently on the output channel, counts down to idle
	typedef enum logic [2:0] {
		SEL_IDLE    = 3'd0,
		SEL_NUL2    = 3'd1,
		SEL_NUL1    = 3'd2,
		SEL_CIPH_HI = 3'd3,
		SEL_CIPH_LO = 3'd4,
		SEL_HEADER  = 3'd5
	} out_sel_t;

	// input block FSM
	typedef enum logic [1:0] {COLLECT, WAIT_OUT, RUN, RETURN} in_state_t;

endpackage
